// File: project.f
+incdir+common
common/issue_pkg.sv
issue/rs_scheduler.sv
issue/reg_status.sv
issue/rob_alloc.sv
hw/rs_bank.sv
hw/issue_top.sv
verif/tb_issue.sv

// File: Makefile
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_issue
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

SOURCES := $(wildcard common/*.sv common/*.svh issue/*.sv hw/*.sv verif/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_issue.sv
/*
 * issue stage testbench: LFSR stimulus, model of the tag table,
 * allocator and stations, checks and watchdog
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module tb_issue import issue_pkg::*; ();
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TRANS    = 2000;
    // up to four stall cycles per issued instruction, plus margin
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 5 * NUM_TRANS) * CLK_PERIOD + 1000;
    localparam int C_REG = 0, C_ADDI = 1, C_LOAD = 2, C_STORE = 3, C_BR = 4, C_JAL = 5;

    logic        clk;
    logic        rst_n;
    pipe_in_t    pipe_in;
    word_t       rs1_data, rs2_data;
    logic        lsq_full;
    cdb_t        cdb;
    logic        commit;
    reg_addr_t   rs1, rs2;
    logic        stall;
    rob_entry_t  rob_input;
    lsq_packet_t lsq_input;
    rs_data_t    dispatch;
    logic        dispatch_valid;

    logic [31:0]  lfsr = 32'hb0949665;
    rob_tag_t     m_tag [32];        // newest writer per register
    rs_data_t     m_rs [`RS_COUNT];
    logic         m_done [16];       // result already on the CDB
    int           head_i, tail_i, cnt, issued, cycles;
    logic         last_stall;
    int           cls;               // class of the instruction on pipe_in
    alu_op_t      exp_op;
    branch_type_t exp_br;
    reg_addr_t    rd, r1, r2;
    word_t        imm, pc;
    pipe_in_t     pi_next;

    issue_top u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd000_0001 : lfsr >> 1;
        end
        return r;
    endfunction

    // register file contents, x0 reads zero
    function automatic word_t reg_read(reg_addr_t r);
        return (r == '0) ? '0 : (32'h0101_0101 * word_t'(r)) ^ 32'h5a3c_0000;
    endfunction

    assign rs1_data = reg_read(rs1);
    assign rs2_data = reg_read(rs2);

    task automatic check_value(string name, logic [127:0] exp_v, logic [127:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAIL %s expected %0h actual %0h", name, exp_v, act_v);
            $display("ERRORS FOUND");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic gen_instr();
        logic [11:0] imm12;
        logic [6:0]  f7;
        logic [2:0]  f3;
        int          v;
        cls     = int'(take_bits(3)) % 6;
        rd      = reg_addr_t'(take_bits(5));
        r1      = reg_addr_t'(take_bits(5));
        r2      = reg_addr_t'(take_bits(5));
        imm12   = 12'(take_bits(12));
        imm     = {{20{imm12[11]}}, imm12};
        pc      = pc + 32'd4;
        exp_op  = ALU_ADD;
        exp_br  = BR_NONE;
        pi_next = '0;
        pi_next.pc         = pc;
        pi_next.prediction = 1'(take_bits(1));
        case (cls)
            C_REG: begin
                v      = int'(take_bits(3)) % 6;
                f7     = (v == 0) ? 7'h00 : (v == 1) ? 7'h20 : 7'h01;
                f3     = (v == 3) ? 3'd1 : (v == 4) ? 3'd4 : (v == 5) ? 3'd7 : 3'd0;
                exp_op = (v == 0) ? ALU_ADD : (v == 1) ? ALU_SUB : (v == 2) ? ALU_MUL :
                         (v == 3) ? ALU_SHL : (v == 4) ? ALU_XOR : ALU_AND;
                pi_next.instruction = {f7, r2, r1, f3, rd, 7'b0110011};
            end
            C_ADDI:  pi_next.instruction = {imm12, r1, 3'b000, rd, 7'b0010011};
            C_LOAD:  pi_next.instruction = {imm12, r1, 3'b010, rd, 7'b0000011};
            C_STORE: pi_next.instruction = {imm12[11:5], r2, r1, 3'b010, imm12[4:0], 7'b0100011};
            C_BR: begin
                f3     = 3'(take_bits(3));
                exp_op = ALU_SUB;
                exp_br = (f3 == 3'd0) ? BR_BEQ : (f3 == 3'd1) ? BR_BNE : BR_OTHER;
                pi_next.branch      = 1'b1;
                pi_next.branch_imm  = {imm[30:0], 1'b0};
                pi_next.instruction = {7'b0, r2, r1, f3, 5'b0, 7'b1100011};
            end
            default: begin // JAL
                pi_next.jump        = 1'b1;
                pi_next.instruction = {imm12, r1, 3'b000, rd, 7'b1101111};
            end
        endcase
    endtask

    task automatic drive_cycle();
        cdb_t     c;
        int       off;
        rob_tag_t t;
        if (!last_stall) begin // packet held while stalled
            gen_instr();
            pipe_in <= pi_next;
        end
        lsq_full <= take_bits(3) == 32'd0 && cycles > 0;
        commit   <= cnt > 0 && m_done[rob_tag_t'(head_i + 1)] && take_bits(2) != 32'd0;
        c = '0;
        if (cnt > 0 && take_bits(2) != 32'd0) begin
            off = int'(take_bits(4));
            for (int k = 0; k < cnt; k++) begin
                t = rob_tag_t'((head_i + (off + k) % cnt) % `ROB_DEPTH + 1);
                if (!c.valid && !m_done[t]) begin // first live tag still waiting
                    c.valid = 1'b1;
                    c.tag   = t;
                    c.value = take_bits(32);
                end
            end
        end
        cdb <= c;
    endtask

    task automatic check_cycle();
        int         free_i, sel;
        logic       exp_stall, exp_dv, writes;
        rob_tag_t   qa, qb, tail_t;
        word_t      va, vb, exp_dest;
        rs_data_t   e;
        rob_itype_t exp_it;
        free_i = -1;
        sel    = -1;
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (!m_rs[i].busy)
                free_i = i;
            if (m_rs[i].busy && m_rs[i].Q_j == '0 && m_rs[i].Q_k == '0)
                sel = i;
        end
        tail_t    = rob_tag_t'(tail_i + 1);
        exp_stall = free_i < 0 || cnt == `ROB_DEPTH || lsq_full;
        exp_dv    = sel >= 0;
        qa = m_tag[r1];
        qb = m_tag[r2];
        va = reg_read(r1);
        vb = reg_read(r2);
        if (qa != '0 && cdb.valid && cdb.tag == qa) begin // same-cycle bypass
            qa = '0;
            va = cdb.value;
        end
        if (qb != '0 && cdb.valid && cdb.tag == qb) begin
            qb = '0;
            vb = cdb.value;
        end
        e = '0;
        e.busy        = 1'b1;
        e.Q_j         = qa;
        e.Q_k         = qb;
        e.V_j         = va;
        e.V_k         = vb;
        e.rob_entry   = tail_t;
        e.alu_op      = exp_op;
        e.branch_type = exp_br;
        if (cls == C_ADDI || cls == C_LOAD || cls == C_STORE) begin
            e.Q_k = '0;
            e.V_k = imm;
        end else if (cls == C_JAL) begin
            e.Q_j = '0;
            e.V_j = pc;
            e.Q_k = '0;
            e.V_k = 32'd4;
        end
        exp_it   = IT_REG;
        exp_dest = word_t'(rd);
        if (cls == C_STORE) begin
            exp_it   = IT_STORE;
            exp_dest = '0;
        end else if (cls == C_BR) begin
            exp_it   = IT_BRANCH;
            exp_dest = pc;
        end else if (cls == C_LOAD) begin
            exp_it = IT_LOAD;
        end
        writes = !exp_stall && cls != C_STORE && cls != C_BR && rd != '0;

        if (cycles == 0) begin
            check_value("reset stall", 128'(0), 128'(stall));
            check_value("reset dispatch_valid", 128'(0), 128'(dispatch_valid));
            check_value("reset rob_number", 128'(1), 128'(rob_input.rob_number));
        end
        check_value("rs1", 128'(r1), 128'(rs1));
        if (cls == C_REG || cls == C_STORE || cls == C_BR)
            check_value("rs2", 128'(r2), 128'(rs2));
        check_value("stall", 128'(exp_stall), 128'(stall));
        if (exp_stall) begin
            check_value("stall rob_number", 128'(0), 128'(rob_input.rob_number));
            check_value("stall lsq flags", 128'(0), 128'({lsq_input.load, lsq_input.store}));
        end else begin
            check_value("rob_number", 128'(tail_t), 128'(rob_input.rob_number));
            check_value("rob itype", 128'(exp_it), 128'(rob_input.itype));
            check_value("rob destination", 128'(exp_dest), 128'(rob_input.destination));
            check_value("rob branch_pred", 128'(pi_next.prediction),
                        128'(rob_input.branch_pred));
            check_value("lsq rob_entry", 128'(tail_t), 128'(lsq_input.rob_entry));
            check_value("lsq flags", 128'({cls == C_LOAD, cls == C_STORE}),
                        128'({lsq_input.load, lsq_input.store}));
            if (cls == C_STORE)
                check_value("store data tag", 128'(qb), 128'(lsq_input.Q_store));
        end
        check_value("dispatch_valid", 128'(exp_dv), 128'(dispatch_valid));
        if (exp_dv)
            check_value("dispatch entry", 128'(m_rs[sel]), 128'(dispatch));

        // advance the model to the next edge
        if (exp_dv)
            m_rs[sel].busy = 1'b0;
        for (int i = 0; i < `RS_COUNT; i++) begin
            if (m_rs[i].busy && cdb.valid && m_rs[i].Q_j != '0 && m_rs[i].Q_j == cdb.tag) begin
                m_rs[i].Q_j = '0;
                m_rs[i].V_j = cdb.value;
            end
            if (m_rs[i].busy && cdb.valid && m_rs[i].Q_k != '0 && m_rs[i].Q_k == cdb.tag) begin
                m_rs[i].Q_k = '0;
                m_rs[i].V_k = cdb.value;
            end
        end
        if (!exp_stall)
            m_rs[free_i] = e;
        for (int r = 1; r < 32; r++) begin
            if (writes && rd == reg_addr_t'(r))
                m_tag[r] = tail_t; // new writer beats the CDB clear
            else if (cdb.valid && m_tag[r] != '0 && m_tag[r] == cdb.tag)
                m_tag[r] = '0;
        end
        if (cdb.valid)
            m_done[cdb.tag] = 1'b1;
        if (!exp_stall) begin
            m_done[tail_t] = 1'b0;
            tail_i = (tail_i + 1) % `ROB_DEPTH;
            cnt++;
            issued++;
        end
        if (commit) begin
            head_i = (head_i + 1) % `ROB_DEPTH;
            cnt--;
        end
        last_stall = exp_stall;
    endtask

    initial begin
        rst_n    = 1'b0;
        pipe_in  = '0;
        lsq_full = 1'b0;
        cdb      = '0;
        commit   = 1'b0;
        for (int r = 0; r < 32; r++)
            m_tag[r] = '0;
        for (int i = 0; i < `RS_COUNT; i++)
            m_rs[i] = '0;
        for (int t = 0; t < 16; t++)
            m_done[t] = 1'b0;
        head_i     = 0;
        tail_i     = 0; // tag 1 comes first
        cnt        = 0;
        issued     = 0;
        cycles     = 0;
        last_stall = 1'b0;
        pc         = 32'h0000_1000;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (issued < NUM_TRANS) begin
            drive_cycle();
            @(negedge clk);
            check_cycle();
            cycles++;
            @(posedge clk);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired with %0d of %0d instructions issued", issued, NUM_TRANS);
    end

endmodule

// File: hw/issue_top.sv
/*
 * issue stage top: scheduler, register status,
 * ROB tag allocator and station bank
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module issue_top import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  pipe_in_t    pipe_in,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  logic        lsq_full,
    input  cdb_t        cdb,
    input  logic        commit,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output logic        stall,
    output rob_entry_t  rob_input,
    output lsq_packet_t lsq_input,
    output rs_data_t    dispatch,
    output logic        dispatch_valid
);
    rob_tag_t             Q_j, Q_k;
    logic [`RS_COUNT-1:0] busy_bus;
    rob_tag_t             rob_tag;
    logic                 rob_full;
    rs_data_t             rs_input;
    rs_idx_t              rs_dest;
    reg_addr_t            issue_dest;
    logic                 issue_writes;
    logic                 issue;

    rs_scheduler u_sched (
        .pipe_in      (pipe_in),
        .busy_bus     (busy_bus),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rob_tag      (rob_tag),
        .rob_full     (rob_full),
        .lsq_full     (lsq_full),
        .Q_j          (Q_j),
        .Q_k          (Q_k),
        .cdb          (cdb),
        .rs_input     (rs_input),
        .rob_input    (rob_input),
        .lsq_input    (lsq_input),
        .rs_dest      (rs_dest),
        .rs1          (rs1),
        .rs2          (rs2),
        .issue_dest   (issue_dest),
        .issue_writes (issue_writes),
        .issue        (issue),
        .stall        (stall)
    );

    reg_status u_regstat (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1          (rs1),
        .rs2          (rs2),
        .Q_j          (Q_j),
        .Q_k          (Q_k),
        .issue_writes (issue_writes),
        .issue_dest   (issue_dest),
        .rob_tag      (rob_tag),
        .cdb          (cdb)
    );

    rob_alloc u_rob (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .commit   (commit),
        .rob_tag  (rob_tag),
        .rob_full (rob_full)
    );

    rs_bank u_rs (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (issue),
        .rs_dest        (rs_dest),
        .rs_input       (rs_input),
        .cdb            (cdb),
        .busy_bus       (busy_bus),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid)
    );

endmodule

// File: hw/rs_bank.sv
/*
 * bank of reservation stations with CDB capture
 * and lowest-index ready dispatch
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module rs_bank import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  rs_idx_t              rs_dest,
    input  rs_data_t             rs_input,
    input  cdb_t                 cdb,
    output logic [`RS_COUNT-1:0] busy_bus,
    output rs_data_t             dispatch,
    output logic                 dispatch_valid
);
    logic [`RS_COUNT-1:0] busy_q;
    rs_data_t             ent_q [`RS_COUNT]; // payload
    logic [`RS_COUNT-1:0] ready;
    rs_idx_t              sel;

    assign busy_bus = busy_q;

    always_comb begin
        for (int i = 0; i < `RS_COUNT; i++)
            ready[i] = busy_q[i] && ent_q[i].Q_j == '0 && ent_q[i].Q_k == '0;
    end

    // lowest-index ready entry goes out
    always_comb begin
        sel = '0;
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (ready[i])
                sel = rs_idx_t'(i);
        end
    end

    assign dispatch_valid = |ready;
    assign dispatch       = dispatch_valid ? ent_q[sel] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            for (int i = 0; i < `RS_COUNT; i++) begin
                if (issue && rs_dest == rs_idx_t'(i))
                    busy_q[i] <= 1'b1;
                else if (dispatch_valid && sel == rs_idx_t'(i))
                    busy_q[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_COUNT; i++) begin
            if (issue && rs_dest == rs_idx_t'(i)) begin
                ent_q[i] <= rs_input;
            end else if (busy_q[i] && cdb.valid) begin
                if (ent_q[i].Q_j != '0 && ent_q[i].Q_j == cdb.tag) begin
                    ent_q[i].Q_j <= '0;
                    ent_q[i].V_j <= cdb.value;
                end
                if (ent_q[i].Q_k != '0 && ent_q[i].Q_k == cdb.tag) begin
                    ent_q[i].Q_k <= '0;
                    ent_q[i].V_k <= cdb.value;
                end
            end
        end
    end

    a_issue_free: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !busy_q[rs_dest]);

endmodule

// File: issue/rob_alloc.sv
/*
 * ROB tag allocator: tags 1..15 in order, freed on commit
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module rob_alloc import issue_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue,
    input  logic     commit,
    output rob_tag_t rob_tag,
    output logic     rob_full
);
    rob_tag_t               head_q; // oldest live tag
    rob_tag_t               tail_q; // next tag to hand out
    logic [`ROB_TAG_W-1:0]  count_q;

    // wrap from the last usable tag back to 1, skipping 0
    function automatic rob_tag_t next_tag(rob_tag_t t);
        return (t == rob_tag_t'(`ROB_DEPTH)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    assign rob_tag  = tail_q;
    assign rob_full = (count_q == `ROB_TAG_W'(`ROB_DEPTH));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= rob_tag_t'(1);
            tail_q  <= rob_tag_t'(1);
            count_q <= '0;
        end else begin
            if (issue)
                tail_q <= next_tag(tail_q);
            if (commit)
                head_q <= next_tag(head_q);
            case ({issue, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    a_commit_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> count_q != '0);

    // pointers meet only when nothing is in flight
    a_empty_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
        count_q == '0 |-> head_q == tail_q);

endmodule

// File: issue/reg_status.sv
/*
 * register status table: ROB tag of the newest writer per register
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module reg_status import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output rob_tag_t  Q_j,
    output rob_tag_t  Q_k,
    input  logic      issue_writes,
    input  reg_addr_t issue_dest,
    input  rob_tag_t  rob_tag,
    input  cdb_t      cdb
);
    localparam int NREGS = 1 << `REG_W;

    rob_tag_t tags_q [NREGS];

    // x0 keeps its reset value of 0
    assign Q_j = tags_q[rs1];
    assign Q_k = tags_q[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++)
                tags_q[i] <= '0;
        end else begin
            for (int i = 1; i < NREGS; i++) begin
                if (issue_writes && issue_dest == reg_addr_t'(i))
                    tags_q[i] <= rob_tag; // newer writer wins over CDB clear
                else if (cdb.valid && cdb.tag != '0 && tags_q[i] == cdb.tag)
                    tags_q[i] <= '0; // value now in the register file
            end
        end
    end

    a_no_x0_rename: assert property (@(posedge clk) disable iff (!rst_n)
        issue_writes |-> !(issue_dest == '0 && rob_tag != '0));

endmodule

// File: issue/rs_scheduler.sv
/*
 * reservation station scheduler: free station pick, decode,
 * station/ROB/LSQ packet build and stall
 */
`timescale 1ns/1ns
`include "issue_defines.svh"

module rs_scheduler import issue_pkg::*; (
    input  pipe_in_t             pipe_in,
    input  logic [`RS_COUNT-1:0] busy_bus,
    input  word_t                rs1_data,
    input  word_t                rs2_data,
    input  rob_tag_t             rob_tag,  // next free ROB tag
    input  logic                 rob_full,
    input  logic                 lsq_full,
    input  rob_tag_t             Q_j,
    input  rob_tag_t             Q_k,
    input  cdb_t                 cdb,
    output rs_data_t             rs_input,
    output rob_entry_t           rob_input,
    output lsq_packet_t          lsq_input,
    output rs_idx_t              rs_dest,
    output reg_addr_t            rs1,
    output reg_addr_t            rs2,
    output reg_addr_t            issue_dest,
    output logic                 issue_writes,
    output logic                 issue,
    output logic                 stall
);
    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ADDI  = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    word_t        ins;
    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    word_t        imm_i, imm_s;
    logic         no_free;
    rob_tag_t     q_j_eff, q_k_eff; // after CDB bypass
    word_t        v_rs1, v_rs2;
    rob_tag_t     q_j, q_k;
    word_t        v_j, v_k;
    alu_op_t      alu_op;
    branch_type_t br_type;
    logic         writes_rd;

    // operand value, taking a result off the CDB in the same cycle
    function automatic word_t fwd_val(rob_tag_t q, word_t rdata, cdb_t c);
        word_t v;
        if (q == '0)
            v = rdata;
        else if (c.valid && c.tag == q)
            v = c.value;
        else
            v = '0; // filled in later by CDB capture
        return v;
    endfunction

    function automatic rob_tag_t fwd_tag(rob_tag_t q, cdb_t c);
        return (c.valid && c.tag == q) ? rob_tag_t'(0) : q;
    endfunction

    assign ins    = pipe_in.instruction;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];
    assign imm_i  = {{(`XLEN-12){ins[31]}}, ins[31:20]};
    assign imm_s  = {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};

    assign rs1        = ins[19:15];
    assign rs2        = ins[24:20];
    assign issue_dest = ins[11:7];

    assign q_j_eff = fwd_tag(Q_j, cdb);
    assign q_k_eff = fwd_tag(Q_k, cdb);
    assign v_rs1   = fwd_val(Q_j, rs1_data, cdb);
    assign v_rs2   = fwd_val(Q_k, rs2_data, cdb);

    // lowest free station wins
    always_comb begin
        rs_dest = '0;
        no_free = 1'b1;
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (!busy_bus[i]) begin
                rs_dest = rs_idx_t'(i);
                no_free = 1'b0;
            end
        end
    end

    assign stall        = no_free | rob_full | lsq_full;
    assign issue        = ~stall;
    assign issue_writes = issue & writes_rd & (issue_dest != '0); // x0 never renamed

    // decode into operands and op
    always_comb begin
        alu_op    = ALU_ADD;
        br_type   = BR_NONE;
        writes_rd = 1'b1;
        v_j       = v_rs1;
        v_k       = v_rs2;
        q_j       = q_j_eff;
        q_k       = q_k_eff;
        if (opcode == OP_RTYPE) begin
            if (funct7 == 7'b0000001) begin
                case (funct3)
                    3'b000:  alu_op = ALU_MUL;
                    3'b001:  alu_op = ALU_SHL;
                    3'b100:  alu_op = ALU_XOR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_SUB;
                endcase
            end else if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                alu_op = ALU_ADD;
            end else begin
                alu_op = ALU_SUB;
            end
        end else if (pipe_in.branch) begin
            alu_op    = ALU_SUB; // compare by subtraction
            writes_rd = 1'b0;
            if (funct3 == 3'b000)
                br_type = BR_BEQ;
            else if (funct3 == 3'b001)
                br_type = BR_BNE;
            else
                br_type = BR_OTHER;
        end else if (opcode == OP_ADDI) begin
            v_k = imm_i;
            q_k = '0;
        end else if (pipe_in.jump) begin
            v_j = pipe_in.pc; // link address pc + 4
            v_k = word_t'(4);
            q_j = '0;
            q_k = '0;
        end else if (opcode == OP_LOAD) begin
            v_k = imm_i;
            q_k = '0;
        end else begin
            // store: station computes the address only
            writes_rd = 1'b0;
            v_k       = imm_s;
            q_k       = '0;
        end
    end

    always_comb begin
        rs_input.busy        = 1'b1;
        rs_input.Q_j         = q_j;
        rs_input.Q_k         = q_k;
        rs_input.V_j         = v_j;
        rs_input.V_k         = v_k;
        rs_input.rob_entry   = rob_tag;
        rs_input.alu_op      = alu_op;
        rs_input.branch_type = br_type;
    end

    always_comb begin
        rob_input.rob_number  = stall ? rob_tag_t'(0) : rob_tag;
        rob_input.branch_pred = pipe_in.prediction;
        rob_input.ready       = 1'b0;
        rob_input.value       = '0; // written back at completion
        rob_input.destination = word_t'(issue_dest);
        rob_input.itype       = IT_REG;
        if (opcode == OP_STORE) begin
            rob_input.itype       = IT_STORE;
            rob_input.destination = '0; // address comes from the LSQ
            rob_input.value       = v_rs2;
            rob_input.ready       = 1'b1;
        end else if (pipe_in.branch) begin
            rob_input.itype       = IT_BRANCH;
            rob_input.value       = pipe_in.branch_imm;
            rob_input.destination = pipe_in.pc;
        end else if (opcode == OP_LOAD) begin
            rob_input.itype = IT_LOAD;
        end
    end

    always_comb begin
        lsq_input.load      = issue && opcode == OP_LOAD;
        lsq_input.store     = issue && opcode == OP_STORE;
        lsq_input.rob_entry = rob_tag;
        lsq_input.Q_store   = lsq_input.store ? q_k_eff : rob_tag_t'(0);
        lsq_input.result    = lsq_input.store ? v_rs2 : word_t'(0); // store data
    end

endmodule

// File: common/issue_pkg.sv
/*
 * issue stage types: vector typedefs, op enums,
 * front-end, station, ROB, LSQ and CDB packets
 */
`include "issue_defines.svh"

package issue_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [`ROB_TAG_W-1:0]         rob_tag_t; // 0 = value present
    typedef logic [`REG_W-1:0]             reg_addr_t;
    typedef logic [$clog2(`RS_COUNT)-1:0]  rs_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_XOR = 3'b011,
        ALU_MUL = 3'b100,
        ALU_SHL = 3'b101
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE  = 2'b00,
        BR_BNE   = 2'b01,
        BR_BEQ   = 2'b10,
        BR_OTHER = 2'b11
    } branch_type_t;

    typedef enum logic [1:0] {
        IT_BRANCH = 2'b00,
        IT_STORE  = 2'b01,
        IT_REG    = 2'b10,
        IT_LOAD   = 2'b11
    } rob_itype_t;

    typedef struct packed {
        word_t instruction;
        word_t pc;
        logic  branch;
        logic  jump;
        logic  prediction;
        word_t branch_imm; // sign-extended branch offset
    } pipe_in_t;

    typedef struct packed {
        logic         busy;
        rob_tag_t     Q_j;
        rob_tag_t     Q_k;
        word_t        V_j;
        word_t        V_k;
        rob_tag_t     rob_entry;
        alu_op_t      alu_op;
        branch_type_t branch_type;
    } rs_data_t;

    typedef struct packed {
        rob_tag_t   rob_number; // 0 marks an empty packet
        rob_itype_t itype;
        word_t      destination;
        word_t      value;
        logic       ready;
        logic       branch_pred;
    } rob_entry_t;

    typedef struct packed {
        logic     load;
        logic     store;
        rob_tag_t rob_entry;
        rob_tag_t Q_store; // producer of the store data
        word_t    result;
    } lsq_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

endpackage

// File: common/issue_defines.svh
/*
 * widths and counts for the issue stage
 */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

`define XLEN      32 // data word width
`define RS_COUNT  4  // reservation stations
`define ROB_TAG_W 4
`define ROB_DEPTH 15 // tag 0 is reserved for "no tag"
`define REG_W     5

`endif
